//--- common/mipsIsaPkg.sv
package mipsIsaPkg;

	// ************************************************************************
	// opcode and funct encodings
	// ************************************************************************
	typedef enum logic [5:0]
	{
		opRType = 6'd0,
		opJ     = 6'd2,
		opBeq   = 6'd4,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcode_t;

	typedef enum logic [5:0]
	{
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnSlt = 6'd42
	} funct_t;

	// ************************************************************************
	// instruction formats
	// ************************************************************************
	typedef struct packed
	{
		opcode_t opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t funct;
	} rFormat_t;

	typedef struct packed
	{
		opcode_t opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFormat_t;

	typedef struct packed
	{
		opcode_t opcode;
		logic [25:0] target;
	} jFormat_t;

	typedef union packed
	{
		rFormat_t r;
		iFormat_t i;
		jFormat_t j;
	} instr_t;

endpackage

//--- common/mipsCtrlPkg.sv
package mipsCtrlPkg;

	typedef enum logic [3:0]
	{
		stReset,
		stFetch,
		stDecode,
		stMemAddr,
		stMemRead,
		stMemWriteBack,
		stMemWrite,
		stExecute,
		stRCompletion,
		stBranch,
		stJump
	} fsmState_t;

	typedef struct packed
	{
		logic pcWriteCond;
		logic pcWrite;
		logic iorD;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic irWrite;
		logic [1:0] pcSource;	// 00 alu, 01 aluOut, 10 jump.
		logic [1:0] aluOp;
		logic [1:0] aluSrcB;	// 00 b, 01 four, 10 imm, 11 imm << 2.
		logic aluSrcA;
		logic regWrite;
		logic regDst;
	} ctrlWord_t;

	typedef enum logic [2:0]
	{
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluFunc_t;

endpackage

//--- control/mainControl.sv
`timescale 1ns/1ps

module mainControl
(
	input logic clk,
	input logic rst,
	input mipsIsaPkg::opcode_t opcode,
	output mipsCtrlPkg::ctrlWord_t ctrl
);

	mipsCtrlPkg::fsmState_t state;
	mipsCtrlPkg::fsmState_t nextState;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= mipsCtrlPkg::stReset;
		else
			state <= nextState;
	end

	// ************************************************************************
	// next state
	// ************************************************************************
	always_comb
	begin
		nextState = mipsCtrlPkg::stReset;
		case (state)
			mipsCtrlPkg::stReset: nextState = mipsCtrlPkg::stFetch;
			mipsCtrlPkg::stFetch: nextState = mipsCtrlPkg::stDecode;
			mipsCtrlPkg::stDecode:
			begin
				case (opcode)
					mipsIsaPkg::opLw,
					mipsIsaPkg::opSw: nextState = mipsCtrlPkg::stMemAddr;
					mipsIsaPkg::opRType: nextState = mipsCtrlPkg::stExecute;
					mipsIsaPkg::opBeq: nextState = mipsCtrlPkg::stBranch;
					mipsIsaPkg::opJ: nextState = mipsCtrlPkg::stJump;
					default: nextState = mipsCtrlPkg::stReset;	// unknown, refetch.
				endcase
			end
			mipsCtrlPkg::stMemAddr:
			begin
				if (opcode == mipsIsaPkg::opLw)
					nextState = mipsCtrlPkg::stMemRead;
				else if (opcode == mipsIsaPkg::opSw)
					nextState = mipsCtrlPkg::stMemWrite;
			end
			mipsCtrlPkg::stMemRead: nextState = mipsCtrlPkg::stMemWriteBack;
			mipsCtrlPkg::stExecute: nextState = mipsCtrlPkg::stRCompletion;
			mipsCtrlPkg::stMemWriteBack,
			mipsCtrlPkg::stMemWrite,
			mipsCtrlPkg::stRCompletion,
			mipsCtrlPkg::stBranch,
			mipsCtrlPkg::stJump: nextState = mipsCtrlPkg::stFetch;
			default: nextState = mipsCtrlPkg::stReset;
		endcase
	end

	// ************************************************************************
	// control word per state
	// ************************************************************************
	always_comb
	begin
		ctrl = '0;
		case (state)
			mipsCtrlPkg::stFetch:
			begin
				ctrl.memRead = 1'b1;
				ctrl.irWrite = 1'b1;
				ctrl.aluSrcB = 2'b01;	// pc + 4.
				ctrl.pcWrite = 1'b1;
			end
			mipsCtrlPkg::stDecode: ctrl.aluSrcB = 2'b11;	// branch target.
			mipsCtrlPkg::stMemAddr:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
			end
			mipsCtrlPkg::stMemRead:
			begin
				ctrl.iorD = 1'b1;
				ctrl.memRead = 1'b1;
			end
			mipsCtrlPkg::stMemWriteBack:
			begin
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsCtrlPkg::stMemWrite:
			begin
				ctrl.iorD = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			mipsCtrlPkg::stExecute:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOp = 2'b10;
			end
			mipsCtrlPkg::stRCompletion:
			begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsCtrlPkg::stBranch:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOp = 2'b01;	// compare by subtract.
				ctrl.pcSource = 2'b01;
				ctrl.pcWriteCond = 1'b1;
			end
			mipsCtrlPkg::stJump:
			begin
				ctrl.pcSource = 2'b10;
				ctrl.pcWrite = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	memExclusive: assert property (@(posedge clk) !(ctrl.memRead && ctrl.memWrite));

	stateLegal: assert property (@(posedge clk) disable iff (rst)
		state inside {mipsCtrlPkg::stReset, mipsCtrlPkg::stFetch, mipsCtrlPkg::stDecode,
			mipsCtrlPkg::stMemAddr, mipsCtrlPkg::stMemRead, mipsCtrlPkg::stMemWriteBack,
			mipsCtrlPkg::stMemWrite, mipsCtrlPkg::stExecute, mipsCtrlPkg::stRCompletion,
			mipsCtrlPkg::stBranch, mipsCtrlPkg::stJump});

endmodule

//--- control/aluControl.sv
`timescale 1ns/1ps

module aluControl
(
	input logic [1:0] aluOp,
	input mipsIsaPkg::funct_t funct,
	output mipsCtrlPkg::aluFunc_t aluFunc
);

	always_comb
	begin
		case (aluOp)
			2'b00: aluFunc = mipsCtrlPkg::aluAdd;	// address and pc math.
			2'b01: aluFunc = mipsCtrlPkg::aluSub;	// beq.
			2'b10:
			begin
				case (funct)
					mipsIsaPkg::fnAdd: aluFunc = mipsCtrlPkg::aluAdd;
					mipsIsaPkg::fnSub: aluFunc = mipsCtrlPkg::aluSub;
					mipsIsaPkg::fnAnd: aluFunc = mipsCtrlPkg::aluAnd;
					mipsIsaPkg::fnOr: aluFunc = mipsCtrlPkg::aluOr;
					mipsIsaPkg::fnSlt: aluFunc = mipsCtrlPkg::aluSlt;
					default: aluFunc = mipsCtrlPkg::aluAdd;
				endcase
			end
			default: aluFunc = mipsCtrlPkg::aluAdd;
		endcase
	end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile
(
	input logic clk,
	input logic rst,
	input logic [4:0] readAddrA,
	input logic [4:0] readAddrB,
	input logic [4:0] writeAddr,
	input logic writeEn,
	input logic [31:0] writeData,
	output logic [31:0] readDataA,
	output logic [31:0] readDataB
);

	logic [31:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEn && (writeAddr != 5'd0))
			regs[writeAddr] <= writeData;	// $zero stays zero.
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu
(
	input logic [31:0] a,
	input logic [31:0] b,
	input mipsCtrlPkg::aluFunc_t func,
	output logic [31:0] result,
	output logic zero
);

	always_comb
	begin
		case (func)
			mipsCtrlPkg::aluAnd: result = a & b;
			mipsCtrlPkg::aluOr: result = a | b;
			mipsCtrlPkg::aluAdd: result = a + b;
			mipsCtrlPkg::aluSub: result = a - b;
			mipsCtrlPkg::aluSlt: result = {31'd0, $signed(a) < $signed(b)};	// signed.
			default: result = '0;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

//--- source/unifiedMemory.sv
`timescale 1ns/1ps

module unifiedMemory
#(
	parameter int memWords = 256
)
(
	input logic clk,
	input logic [31:0] addr,
	input logic [31:0] writeData,
	input logic writeEn,
	input logic bootEn,
	input logic [31:0] bootAddr,
	input logic [31:0] bootData,
	output logic [31:0] readData
);

	localparam int idxW = $clog2(memWords);

	logic [31:0] mem [memWords];

	always_ff @(posedge clk)
	begin
		if (bootEn)
			mem[bootAddr[idxW+1:2]] <= bootData;	// loader wins.
		else if (writeEn)
			mem[addr[idxW+1:2]] <= writeData;
	end

	assign readData = mem[addr[idxW+1:2]];

	bootVsCore: assert property (@(posedge clk) !(writeEn && bootEn));

endmodule

//--- source/multicycleDatapath.sv
`timescale 1ns/1ps

module multicycleDatapath
(
	input logic clk,
	input logic rst,
	input mipsCtrlPkg::ctrlWord_t ctrl,
	input mipsCtrlPkg::aluFunc_t aluFunc,
	input logic [31:0] memReadData,
	output mipsIsaPkg::instr_t instr,
	output logic [31:0] memAddr,
	output logic [31:0] memWriteData,
	output logic [31:0] pc
);

	logic [31:0] pcReg;
	mipsIsaPkg::instr_t ir;
	logic [31:0] mdr;
	logic [31:0] regA;
	logic [31:0] regB;
	logic [31:0] aluOut;

	logic [31:0] rfDataA;
	logic [31:0] rfDataB;
	logic [31:0] aluA;
	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic aluZero;
	logic [31:0] signImm;
	logic [31:0] jumpTarget;
	logic [31:0] pcNext;
	logic pcEn;
	logic [4:0] writeReg;
	logic [31:0] writeBack;

	// ************************************************************************
	// operand and result muxes
	// ************************************************************************
	assign signImm = {{16{ir.i.imm[15]}}, ir.i.imm};
	assign jumpTarget = {pcReg[31:28], ir.j.target, 2'b00};

	assign aluA = ctrl.aluSrcA ? regA : pcReg;

	always_comb
	begin
		case (ctrl.aluSrcB)
			2'b00: aluB = regB;
			2'b01: aluB = 32'd4;
			2'b10: aluB = signImm;
			default: aluB = {signImm[29:0], 2'b00};	// word offset.
		endcase
	end

	assign writeReg = ctrl.regDst ? ir.r.rd : ir.r.rt;
	assign writeBack = ctrl.memToReg ? mdr : aluOut;

	always_comb
	begin
		case (ctrl.pcSource)
			2'b01: pcNext = aluOut;
			2'b10: pcNext = jumpTarget;
			default: pcNext = aluResult;
		endcase
	end

	assign pcEn = ctrl.pcWrite | (ctrl.pcWriteCond & aluZero);

	// ************************************************************************
	// state registers
	// ************************************************************************
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pcReg <= '0;
			ir <= '0;
			mdr <= '0;
			regA <= '0;
			regB <= '0;
			aluOut <= '0;
		end
		else
		begin
			if (pcEn)
				pcReg <= pcNext;
			if (ctrl.irWrite)
				ir <= memReadData;
			if (ctrl.memRead)
				mdr <= memReadData;
			regA <= rfDataA;
			regB <= rfDataB;
			aluOut <= aluResult;	// held one cycle for the next state.
		end
	end

	regFile regFile_inst
	(
		.clk(clk),
		.rst(rst),
		.readAddrA(ir.r.rs),
		.readAddrB(ir.r.rt),
		.writeAddr(writeReg),
		.writeEn(ctrl.regWrite),
		.writeData(writeBack),
		.readDataA(rfDataA),
		.readDataB(rfDataB)
	);

	alu alu_inst
	(
		.a(aluA),
		.b(aluB),
		.func(aluFunc),
		.result(aluResult),
		.zero(aluZero)
	);

	assign instr = ir;
	assign memAddr = ctrl.iorD ? aluOut : pcReg;
	assign memWriteData = regB;
	assign pc = pcReg;

endmodule

//--- source/mipsCore.sv
`timescale 1ns/1ps

module mipsCore
#(
	parameter int memWords = 256
)
(
	input logic clk,
	input logic rst,
	input logic bootEn,
	input logic [31:0] bootAddr,
	input logic [31:0] bootData,
	output logic [31:0] pc,
	output logic storeEn,
	output logic [31:0] storeAddr,
	output logic [31:0] storeData
);

	mipsCtrlPkg::ctrlWord_t ctrl;
	mipsCtrlPkg::aluFunc_t aluFunc;
	mipsIsaPkg::instr_t instr;
	logic [31:0] memAddr;
	logic [31:0] memReadData;
	logic [31:0] memWriteData;

	mainControl mainControl_inst
	(
		.clk(clk),
		.rst(rst),
		.opcode(instr.r.opcode),
		.ctrl(ctrl)
	);

	aluControl aluControl_inst
	(
		.aluOp(ctrl.aluOp),
		.funct(instr.r.funct),
		.aluFunc(aluFunc)
	);

	multicycleDatapath multicycleDatapath_inst
	(
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.aluFunc(aluFunc),
		.memReadData(memReadData),
		.instr(instr),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.pc(pc)
	);

	unifiedMemory #(.memWords(memWords)) unifiedMemory_inst
	(
		.clk(clk),
		.addr(memAddr),
		.writeData(memWriteData),
		.writeEn(ctrl.memWrite),
		.bootEn(bootEn),
		.bootAddr(bootAddr),
		.bootData(bootData),
		.readData(memReadData)
	);

	// store monitor port.
	assign storeEn = ctrl.memWrite;
	assign storeAddr = memAddr;
	assign storeData = memWriteData;

endmodule

//--- verif/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

	localparam int memWords = 256;

	// reset state plus every executed instruction up to the last store.
	localparam int progCycles = 1 + 3 * 5 + 5 * 4 + 8 * 4 + 2 * 3 + 3 + 3;
	localparam int drainCycles = 40;
	localparam int cycleLimit = progCycles + drainCycles + 40;

	typedef struct packed
	{
		logic [31:0] addr;
		logic [31:0] data;
	} memEntry_t;

	logic clk;
	logic rst;
	logic bootEn;
	logic [31:0] bootAddr;
	logic [31:0] bootData;
	logic [31:0] pc;
	logic storeEn;
	logic [31:0] storeAddr;
	logic [31:0] storeData;

	integer seed = 32'h5e8f;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] marker = 32'hbad0_bad0;
	memEntry_t progTable[$];
	memEntry_t expTable[$];
	int storeIdx = 0;
	int cycleCount = 0;
	logic rstApplied = 1'b0;

	mipsCore #(.memWords(memWords)) mipsCore_inst
	(
		.clk(clk),
		.rst(rst),
		.bootEn(bootEn),
		.bootAddr(bootAddr),
		.bootData(bootData),
		.pc(pc),
		.storeEn(storeEn),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ************************************************************************
	// instruction encoding and table building
	// ************************************************************************
	function automatic logic [31:0] encodeI(input mipsIsaPkg::opcode_t op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input mipsIsaPkg::funct_t fn);
		return {mipsIsaPkg::opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [31:0] target);
		return {mipsIsaPkg::opJ, target[27:2]};
	endfunction

	task automatic addWord(input logic [31:0] addr, input logic [31:0] data);
		memEntry_t entry;
		entry.addr = addr;
		entry.data = data;
		progTable.push_back(entry);
	endtask

	task automatic addStore(input logic [31:0] addr, input logic [31:0] data);
		memEntry_t entry;
		entry.addr = addr;
		entry.data = data;
		expTable.push_back(entry);
	endtask

	task automatic buildProgram();
		addWord(32'h00, encodeI(mipsIsaPkg::opLw, 5'd0, 5'd1, 16'h0080));
		addWord(32'h04, encodeI(mipsIsaPkg::opLw, 5'd0, 5'd2, 16'h0084));
		addWord(32'h08, encodeI(mipsIsaPkg::opLw, 5'd0, 5'd8, 16'h0088));
		addWord(32'h0c, encodeR(5'd1, 5'd2, 5'd3, mipsIsaPkg::fnAdd));
		addWord(32'h10, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd3, 16'h00a0));
		addWord(32'h14, encodeR(5'd1, 5'd2, 5'd4, mipsIsaPkg::fnSub));
		addWord(32'h18, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd4, 16'h00a4));
		addWord(32'h1c, encodeR(5'd1, 5'd2, 5'd5, mipsIsaPkg::fnAnd));
		addWord(32'h20, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd5, 16'h00a8));
		addWord(32'h24, encodeR(5'd1, 5'd2, 5'd6, mipsIsaPkg::fnOr));
		addWord(32'h28, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd6, 16'h00ac));
		addWord(32'h2c, encodeR(5'd1, 5'd2, 5'd7, mipsIsaPkg::fnSlt));
		addWord(32'h30, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd7, 16'h00b0));
		addWord(32'h34, encodeI(mipsIsaPkg::opBeq, 5'd1, 5'd1, 16'h0001));	// taken.
		addWord(32'h38, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd8, 16'h00c0));	// marker, skipped.
		addWord(32'h3c, encodeI(mipsIsaPkg::opBeq, 5'd1, 5'd2, 16'h0001));	// not taken.
		addWord(32'h40, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd3, 16'h00b4));
		addWord(32'h44, 32'hfc00_0000);	// opcode 63.
		addWord(32'h48, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd4, 16'h00b8));
		addWord(32'h4c, encodeJ(32'h54));
		addWord(32'h50, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd8, 16'h00c4));	// marker, skipped.
		addWord(32'h54, encodeI(mipsIsaPkg::opSw, 5'd0, 5'd5, 16'h00bc));
		addWord(32'h58, encodeJ(32'h58));	// park here.
		addWord(32'h80, opA);
		addWord(32'h84, opB);
		addWord(32'h88, marker);
	endtask

	task automatic buildExpected();
		logic [31:0] sltVal;
		sltVal = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
		addStore(32'ha0, opA + opB);
		addStore(32'ha4, opA - opB);
		addStore(32'ha8, opA & opB);
		addStore(32'hac, opA | opB);
		addStore(32'hb0, sltVal);
		addStore(32'hb4, opA + opB);
		addStore(32'hb8, opA - opB);
		addStore(32'hbc, opA & opB);
	endtask

	task automatic failRun(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// ************************************************************************
	// stimulus
	// ************************************************************************
	initial
	begin
		rst = 1'b1;
		bootEn = 1'b0;
		bootAddr = '0;
		bootData = '0;
		opA = $random(seed);
		opB = $random(seed);
		if (opB == opA)
			opB = opA ^ 32'h1;	// second beq must fall through.
		buildProgram();
		buildExpected();
		repeat (3) @(posedge clk);
		foreach (progTable[i])
		begin
			bootEn <= 1'b1;
			bootAddr <= progTable[i].addr;
			bootData <= progTable[i].data;
			@(posedge clk);
		end
		bootEn <= 1'b0;
		rst <= 1'b0;
		wait (storeIdx == expTable.size());
		repeat (drainCycles) @(posedge clk);	// self jump, no more stores.
		$display("SIMULATION PASSED");
		$finish;
	end

	// ************************************************************************
	// monitors
	// ************************************************************************
	always @(posedge clk)
	begin
		if (rstApplied && (rst || cycleCount < 2))
		begin
			assert (!storeEn)
			else failRun("store enable went high before the first instruction");
			assert (pc == 32'd0)
			else failRun($sformatf("[FAIL] pc: got 0x%h expected 0x%h", pc, 32'd0));
		end
		if (!rst && storeEn)
		begin
			assert (storeIdx < expTable.size())
			else failRun($sformatf("unexpected extra store to address 0x%h", storeAddr));
			if (storeIdx < expTable.size())
			begin
				assert (storeAddr === expTable[storeIdx].addr)
				else failRun($sformatf("[FAIL] storeAddr: got 0x%h expected 0x%h",
					storeAddr, expTable[storeIdx].addr));
				assert (storeData === expTable[storeIdx].data)
				else failRun($sformatf("[FAIL] storeData: got 0x%h expected 0x%h",
					storeData, expTable[storeIdx].data));
				storeIdx++;
			end
		end
		if (rst)
			rstApplied = 1'b1;	// registers hold reset values from here on.
		else
		begin
			cycleCount++;
			if (cycleCount >= cycleLimit)
				failRun($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
					cycleCount, storeIdx, expTable.size()));
		end
	end

endmodule

//--- build.f
common/mipsIsaPkg.sv
common/mipsCtrlPkg.sv
control/mainControl.sv
control/aluControl.sv
source/regFile.sv
source/alu.sv
source/unifiedMemory.sv
source/multicycleDatapath.sv
source/mipsCore.sv
verif/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mips_multicycle

sources:
  - common/mipsIsaPkg.sv
  - common/mipsCtrlPkg.sv
  - control/mainControl.sv
  - control/aluControl.sv
  - source/regFile.sv
  - source/alu.sv
  - source/unifiedMemory.sv
  - source/multicycleDatapath.sv
  - source/mipsCore.sv
  - target: test
    files:
      - verif/mipsCoreTb.sv
